// File: hdl/rv_wb_settings.svh
`ifndef RV_WB_SETTINGS_SVH
`define RV_WB_SETTINGS_SVH

// Data path width. The 64-bit product handling assumes 32
`define RV_XLEN 32

// ebreak: SYSTEM opcode with funct12 = 1
`define RV_EBREAK 32'h0010_0073

`endif

// File: hdl/rv_wb_pkg.sv
`default_nettype none

`include "rv_wb_settings.svh"

package rv_wb_pkg;

  // Write-back source select; unused codes produce zero
  typedef enum logic [2:0] {
    res_alu      = 3'd0,
    res_load     = 3'd1,
    res_pc_plus4 = 3'd2,
    res_csr      = 3'd4,
    res_m_ext    = 3'd5
  } res_src_e;

  // Load funct3 codes
  localparam logic [2:0] f3_lb  = 3'd0;
  localparam logic [2:0] f3_lh  = 3'd1;
  localparam logic [2:0] f3_lw  = 3'd2;
  localparam logic [2:0] f3_lbu = 3'd4;
  localparam logic [2:0] f3_lhu = 3'd5;

  // Multiply funct3 codes, bit 2 set selects a division
  localparam logic [2:0] f3_mul    = 3'd0;
  localparam logic [2:0] f3_mulh   = 3'd1;
  localparam logic [2:0] f3_mulhsu = 3'd2;
  localparam logic [2:0] f3_mulhu  = 3'd3;

  // Raw memory word seen as bytes or as halfwords
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } data_word_u;

  typedef struct packed {
    logic [31:0]          instr;
    logic [`RV_XLEN-1:0]  pc;
    res_src_e             res_src;
    logic [4:0]           rd;
    logic                 reg_write;
    logic [`RV_XLEN-1:0]  alu_result;
    logic [`RV_XLEN-1:0]  mem_rdata;
    logic [`RV_XLEN-1:0]  csr_rdata;
    logic [`RV_XLEN-1:0]  div_result;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [63:0]          product_64;
    logic                 trap;
    logic [1:0]           trap_code;
  } mem_in_t;

  // Same as mem_in_t with the aligned load value in place of the raw word
  typedef struct packed {
    logic [31:0]          instr;
    logic [`RV_XLEN-1:0]  pc;
    res_src_e             res_src;
    logic [4:0]           rd;
    logic                 reg_write;
    logic [`RV_XLEN-1:0]  alu_result;
    logic [`RV_XLEN-1:0]  ld_data;
    logic [`RV_XLEN-1:0]  csr_rdata;
    logic [`RV_XLEN-1:0]  div_result;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [63:0]          product_64;
    logic                 trap;
    logic [1:0]           trap_code;
  } wb_in_t;

  typedef struct packed {
    logic                 en;
    logic [4:0]           addr;
    logic [`RV_XLEN-1:0]  data;
  } rf_write_t;

  typedef struct packed {
    logic [31:0]          instr;
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [`RV_XLEN-1:0]  rd_data;
    logic                 trap;
    logic [1:0]           trap_code;
    logic                 reg_write;
  } retire_t;

endpackage

`default_nettype wire

// File: hdl/rv_load_align.sv
`timescale 1ns/100ps
`default_nettype none

module rv_load_align (
  input  rv_wb_pkg::data_word_u word,
  input  logic [1:0]            offset,
  input  logic [2:0]            funct3,
  output logic [31:0]           value
);
  import rv_wb_pkg::*;

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // Byte lane from the full offset, halfword lane from offset bit 1
  assign ld_byte = word.bytes[offset];
  assign ld_half = word.halves[offset[1]];

  always_comb begin
    case (funct3)
      f3_lb: begin
        value = {{24{ld_byte[7]}}, ld_byte};
      end
      f3_lh: begin
        value = {{16{ld_half[15]}}, ld_half};
      end
      f3_lbu: begin
        value = {24'd0, ld_byte};
      end
      f3_lhu: begin
        value = {16'd0, ld_half};
      end
      f3_lw: begin
        value = word.bytes;
      end
      default: begin
        // Not a load, pass the word through
        value = word.bytes;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_mul_sign_fix.sv
`timescale 1ns/100ps
`default_nettype none

module rv_mul_sign_fix (
  input  logic [63:0] product_64,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic [2:0]  funct3,
  output logic [31:0] result
);
  import rv_wb_pkg::*;

  logic [31:0] prod_lo;
  logic [31:0] prod_hi;
  logic [31:0] fix_rs1_neg;
  logic [31:0] fix_rs2_neg;

  assign prod_lo = product_64[31:0];
  assign prod_hi = product_64[63:32];

  // Signed high half = unsigned high half minus the other operand
  // for each operand whose sign bit is set
  assign fix_rs1_neg = rs1_data[31] ? rs2_data : 32'd0;
  assign fix_rs2_neg = rs2_data[31] ? rs1_data : 32'd0;

  always_comb begin
    case (funct3)
      f3_mul: begin
        result = prod_lo;
      end
      f3_mulh: begin
        result = prod_hi - fix_rs1_neg - fix_rs2_neg;
      end
      f3_mulhsu: begin
        result = prod_hi - fix_rs1_neg;
      end
      f3_mulhu: begin
        result = prod_hi;
      end
      default: begin
        result = prod_lo;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_stage_mem.sv
`timescale 1ns/100ps
`default_nettype none

module rv_stage_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_wb_pkg::mem_in_t s_data,
  input  logic               s_valid,
  output logic               s_ready,
  output rv_wb_pkg::wb_in_t  m_data,
  output logic               m_valid,
  input  logic               m_ready
);
  import rv_wb_pkg::*;

  logic       s_accept;
  data_word_u raw_word;
  logic [2:0] funct3;
  logic [31:0] ld_value;
  wb_in_t     next_data;

  assign s_ready  = !m_valid || m_ready;
  assign s_accept = s_valid && s_ready;

  assign raw_word = s_data.mem_rdata;
  assign funct3   = s_data.instr[14:12];

  // Load alignment on the incoming instruction
  rv_load_align i_load_align (
    .word   (raw_word),
    .offset (s_data.alu_result[1:0]),
    .funct3 (funct3),
    .value  (ld_value)
  );

  always_comb begin
    next_data.instr      = s_data.instr;
    next_data.pc         = s_data.pc;
    next_data.res_src    = s_data.res_src;
    next_data.rd         = s_data.rd;
    next_data.reg_write  = s_data.reg_write;
    next_data.alu_result = s_data.alu_result;
    next_data.ld_data    = ld_value;
    next_data.csr_rdata  = s_data.csr_rdata;
    next_data.div_result = s_data.div_result;
    next_data.rs1_data   = s_data.rs1_data;
    next_data.rs2_data   = s_data.rs2_data;
    next_data.product_64 = s_data.product_64;
    next_data.trap       = s_data.trap;
    next_data.trap_code  = s_data.trap_code;
  end

  // Occupancy: filled on accept, emptied when taken with nothing behind
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (s_accept) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s_accept) begin
      m_data <= next_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_stage_wb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_wb_settings.svh"

module rv_stage_wb (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_wb_pkg::wb_in_t    s_data,
  input  logic                 s_valid,
  output logic                 s_ready,
  output rv_wb_pkg::retire_t   m_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output rv_wb_pkg::rf_write_t rf_write,
  output logic                 ebreak,
  output logic                 trap
);
  import rv_wb_pkg::*;

  logic                s_accept;
  logic [2:0]          funct3;
  logic [`RV_XLEN-1:0] mul_result;
  logic [`RV_XLEN-1:0] m_ext_result;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] rd_data;
  logic                is_ebreak;

  assign s_ready  = !m_valid || m_ready;
  assign s_accept = s_valid && s_ready;

  assign funct3 = s_data.instr[14:12];

  // Signed correction of the unsigned product
  rv_mul_sign_fix i_mul_sign_fix (
    .product_64 (s_data.product_64),
    .rs1_data   (s_data.rs1_data),
    .rs2_data   (s_data.rs2_data),
    .funct3     (funct3),
    .result     (mul_result)
  );

  // Divisions finish upstream, multiplies finish here
  assign m_ext_result = funct3[2] ? s_data.div_result : mul_result;
  assign pc_plus4     = s_data.pc + `RV_XLEN'(4);

  // Result mux
  always_comb begin
    case (s_data.res_src)
      res_alu:      rd_data = s_data.alu_result;
      res_load:     rd_data = s_data.ld_data;
      res_pc_plus4: rd_data = pc_plus4;
      res_csr:      rd_data = s_data.csr_rdata;
      res_m_ext:    rd_data = m_ext_result;
      default:      rd_data = '0;
    endcase
  end

  // Register file write in the accepting cycle, suppressed for traps
  assign rf_write.en   = s_accept && s_data.reg_write && !s_data.trap;
  assign rf_write.addr = s_data.rd;
  assign rf_write.data = rd_data;

  assign is_ebreak = (s_data.instr == `RV_EBREAK);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      m_data  <= '0;
      ebreak  <= 1'b0;
      trap    <= 1'b0;
    end else begin
      if (s_accept) begin
        m_valid            <= 1'b1;
        m_data.instr       <= s_data.instr;
        m_data.pc          <= s_data.pc;
        m_data.rs1_data    <= s_data.rs1_data;
        m_data.rs2_data    <= s_data.rs2_data;
        m_data.rd_data     <= rd_data;
        m_data.trap        <= s_data.trap;
        m_data.trap_code   <= s_data.trap_code;
        m_data.reg_write   <= s_data.reg_write;
        // Halt flags stay set until reset
        ebreak             <= ebreak || is_ebreak;
        trap               <= trap || s_data.trap;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_retire_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_retire_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_wb_pkg::mem_in_t   in_data,
  input  logic                 in_valid,
  output logic                 in_ready,
  output rv_wb_pkg::retire_t   ret_data,
  output logic                 ret_valid,
  input  logic                 ret_ready,
  output rv_wb_pkg::rf_write_t rf_write,
  output logic                 ebreak,
  output logic                 trap
);
  import rv_wb_pkg::*;

  // MEM to WB link
  wb_in_t mem_data;
  logic   mem_valid;
  logic   mem_ready;

  rv_stage_mem i_stage_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (in_data),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .m_data  (mem_data),
    .m_valid (mem_valid),
    .m_ready (mem_ready)
  );

  rv_stage_wb i_stage_wb (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_data   (mem_data),
    .s_valid  (mem_valid),
    .s_ready  (mem_ready),
    .m_data   (ret_data),
    .m_valid  (ret_valid),
    .m_ready  (ret_ready),
    .rf_write (rf_write),
    .ebreak   (ebreak),
    .trap     (trap)
  );

endmodule

`default_nettype wire

// File: dv/rv_retire_tests.svh
`ifndef RV_RETIRE_TESTS_SVH
`define RV_RETIRE_TESTS_SVH

localparam logic [31:0] edge_vals [0:4] = '{32'd0, 32'hffff_ffff, 32'h8000_0000,
                                            32'd1, 32'h7fff_ffff};

// OP opcode keeps random words clear of the EBREAK encoding
function automatic mem_in_t new_instr(input logic [2:0] f3, input res_src_e src);
  mem_in_t     ins;
  logic [31:0] r;
  r              = $urandom();
  ins.instr      = {r[31:15], f3, r[11:7], 7'h33};
  ins.pc         = $urandom() & 32'hffff_fffc;
  ins.res_src    = src;
  ins.rd         = r[11:7];
  ins.reg_write  = 1'b1;
  ins.alu_result = $urandom();
  ins.mem_rdata  = $urandom();
  ins.csr_rdata  = $urandom();
  ins.div_result = $urandom();
  ins.rs1_data   = $urandom();
  ins.rs2_data   = $urandom();
  ins.product_64 = {32'd0, ins.rs1_data} * {32'd0, ins.rs2_data};
  ins.trap       = 1'b0;
  ins.trap_code  = 2'd0;
  return ins;
endfunction

function automatic mem_in_t with_operands(input mem_in_t ins, input logic [31:0] a,
                                          input logic [31:0] b);
  ins.rs1_data   = a;
  ins.rs2_data   = b;
  ins.product_64 = {32'd0, a} * {32'd0, b};
  return ins;
endfunction

task automatic send_load(input logic [2:0] f3, input logic [1:0] offset, input logic [31:0] word);
  mem_in_t ins;
  ins                 = new_instr(f3, res_load);
  ins.alu_result[1:0] = offset;
  ins.mem_rdata       = word;
  send_instr(ins);
endtask

task automatic test_reset();
  check_equal(ret_valid, 1'b0, "ret_valid after reset");
  check_equal(rf_write.en, 1'b0, "rf_write.en after reset");
  check_equal(ebreak, 1'b0, "ebreak after reset");
  check_equal(trap, 1'b0, "trap after reset");
  check_equal(in_ready, 1'b1, "in_ready after reset");
  check_equal(ret_data == '0, 1'b1, "ret_data cleared by reset");
endtask

task automatic test_result_select();
  mem_in_t ins;
  send_instr(new_instr(3'd0, res_alu));
  send_instr(new_instr(3'd0, res_csr));
  send_instr(new_instr(3'd0, res_pc_plus4));
  ins           = new_instr(3'd0, res_alu);
  ins.reg_write = 1'b0;
  send_instr(ins);
  // Unused source code selects zero
  send_instr(new_instr(3'd0, res_src_e'(3'd3)));
  wait_drained();
endtask

task automatic test_loads();
  logic [31:0] word;
  for (int rep = 0; rep < 3; rep++) begin
    for (int off = 0; off < 4; off++) begin
      word = (rep == 2) ? 32'h807f_ff01 : $urandom();
      send_load(f3_lb, off[1:0], word);
      send_load(f3_lbu, off[1:0], word);
    end
    for (int off = 0; off < 4; off += 2) begin
      word = (rep == 2) ? 32'h807f_ff01 : $urandom();
      send_load(f3_lh, off[1:0], word);
      send_load(f3_lhu, off[1:0], word);
    end
    send_load(f3_lw, 2'd0, $urandom());
  end
  wait_drained();
endtask

task automatic test_mul_div();
  logic [2:0] f3;
  for (int f = 0; f < 4; f++) begin
    f3 = f[2:0];
    foreach (edge_vals[i]) begin
      foreach (edge_vals[j]) begin
        send_instr(with_operands(new_instr(f3, res_m_ext), edge_vals[i], edge_vals[j]));
      end
    end
    repeat (6) send_instr(new_instr(f3, res_m_ext));
  end
  // Divisions pass div_result straight through
  for (int f = 4; f < 8; f++) begin
    send_instr(new_instr(f[2:0], res_m_ext));
  end
  wait_drained();
endtask

task automatic test_backpressure();
  res_src_e srcs [0:3];
  srcs       = '{res_alu, res_csr, res_pc_plus4, res_m_ext};
  burst_done = 1'b0;
  fork
    begin
      for (int n = 0; n < 40; n++) begin
        send_instr(new_instr(3'($urandom_range(0, 7)), srcs[$urandom_range(0, 3)]));
      end
      burst_done = 1'b1;
    end
    begin
      while (!burst_done) begin
        @(posedge clk);
        #(drive_delay);
        ret_ready = 1'($urandom_range(0, 1));
      end
    end
  join
  wait_drained();
endtask

task automatic test_latency();
  ret_ready = 1'b1;
  send_instr(new_instr(3'd0, res_alu));
  // MEM holds the instruction now and WB writes the register file this cycle
  check_equal(rf_write.en, 1'b1, "rf_write pulse in the cycle after acceptance");
  check_equal(ret_valid, 1'b0, "ret_valid in the cycle after acceptance");
  @(posedge clk);
  #(drive_delay);
  check_equal(rf_write.en, 1'b0, "rf_write pulse lasts one cycle");
  check_equal(ret_valid, 1'b1, "ret_valid one edge after acceptance");
  @(posedge clk);
  #(drive_delay);
  check_equal(exp_ret.size(), 0, "record taken two edges after acceptance");
  wait_drained();
endtask

task automatic test_halt();
  mem_in_t ins;
  check_equal(ebreak, 1'b0, "ebreak before halt test");
  check_equal(trap, 1'b0, "trap before halt test");
  ins           = new_instr(3'd0, res_alu);
  ins.instr     = `RV_EBREAK;
  ins.reg_write = 1'b0;
  send_instr(ins);
  wait_drained();
  check_equal(ebreak, 1'b1, "ebreak set by EBREAK");
  check_equal(trap, 1'b0, "trap clear after EBREAK");
  // Trap keeps reg_write set, the write must still be dropped
  ins           = new_instr(3'd0, res_alu);
  ins.trap      = 1'b1;
  ins.trap_code = 2'd2;
  send_instr(ins);
  send_instr(new_instr(3'd0, res_csr));
  wait_drained();
  check_equal(ebreak, 1'b1, "ebreak sticky");
  check_equal(trap, 1'b1, "trap sticky");
endtask

`endif

// File: dv/rv_retire_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_wb_settings.svh"

module rv_retire_tb;
  import rv_wb_pkg::*;

  localparam int clk_period   = 40;
  localparam int drive_delay  = 2;
  localparam int total_instrs = 216;
  // Back-pressure can stretch a burst to a few cycles per instruction
  localparam int cycle_limit  = 8 * total_instrs + 200;

  logic      clk;
  logic      rst_n;
  mem_in_t   in_data;
  logic      in_valid;
  logic      in_ready;
  retire_t   ret_data;
  logic      ret_valid;
  logic      ret_ready;
  rf_write_t rf_write;
  logic      ebreak;
  logic      trap;

  // Expected responses, queued at acceptance and consumed by the monitor
  retire_t   exp_ret[$];
  rf_write_t exp_rf[$];
  retire_t   ret_item;
  rf_write_t rf_item;
  retire_t   held_data;
  logic      held_valid;
  logic      burst_done;
  int        cycle_count;

  rv_retire_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .ret_data  (ret_data),
    .ret_valid (ret_valid),
    .ret_ready (ret_ready),
    .rf_write  (rf_write),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
      $display("FAIL: see errors above");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("FAIL: see errors above");
    $fatal(1, "Run aborted");
  endtask

  // Load rule: shift the addressed lane down, then extend
  function automatic logic [31:0] load_model(input logic [31:0] word, input logic [1:0] offset,
                                             input logic [2:0] f3);
    logic [31:0] shifted;
    shifted = word >> (8 * offset);
    case (f3)
      f3_lb:   return {{24{shifted[7]}}, shifted[7:0]};
      f3_lh:   return {{16{shifted[15]}}, shifted[15:0]};
      f3_lbu:  return {24'd0, shifted[7:0]};
      f3_lhu:  return {16'd0, shifted[15:0]};
      default: return word;
    endcase
  endfunction

  // Signed operands are extended to 64 bits before a plain multiply
  function automatic logic [31:0] mul_model(input logic [31:0] a, input logic [31:0] b,
                                            input logic [2:0] f3);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    a_ext = (f3 == f3_mulh || f3 == f3_mulhsu) ? {{32{a[31]}}, a} : {32'd0, a};
    b_ext = (f3 == f3_mulh) ? {{32{b[31]}}, b} : {32'd0, b};
    prod  = a_ext * b_ext;
    return (f3 == f3_mul) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic logic [31:0] expected_rd(input mem_in_t ins);
    logic [2:0] f3;
    f3 = ins.instr[14:12];
    case (ins.res_src)
      res_alu:      return ins.alu_result;
      res_load:     return load_model(ins.mem_rdata, ins.alu_result[1:0], f3);
      res_pc_plus4: return ins.pc + 32'd4;
      res_csr:      return ins.csr_rdata;
      res_m_ext:    return f3[2] ? ins.div_result : mul_model(ins.rs1_data, ins.rs2_data, f3);
      default:      return 32'd0;
    endcase
  endfunction

  // in_ready is sampled at the falling edge, returns a short delay after the accepting edge
  task automatic send_instr(input mem_in_t ins);
    retire_t   exp_r;
    rf_write_t exp_w;
    in_data  = ins;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    exp_r           = '0;
    exp_r.instr     = ins.instr;
    exp_r.pc        = ins.pc;
    exp_r.rs1_data  = ins.rs1_data;
    exp_r.rs2_data  = ins.rs2_data;
    exp_r.rd_data   = expected_rd(ins);
    exp_r.trap      = ins.trap;
    exp_r.trap_code = ins.trap_code;
    exp_r.reg_write = ins.reg_write;
    exp_ret.push_back(exp_r);
    if (ins.reg_write && !ins.trap) begin
      exp_w.en   = 1'b1;
      exp_w.addr = ins.rd;
      exp_w.data = exp_r.rd_data;
      exp_rf.push_back(exp_w);
    end
    #(drive_delay);
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    ret_ready = 1'b1;
    do begin
      @(posedge clk);
      #(drive_delay);
    end while (exp_ret.size() != 0);
  endtask

  `include "rv_retire_tests.svh"

  // Response monitor, compares in order against the queues
  always @(posedge clk) begin
    if (rst_n) begin
      if (rf_write.en) begin
        if (exp_rf.size() == 0) begin
          abort_run("register-file write with no instruction expecting one");
        end else begin
          rf_item = exp_rf.pop_front();
          check_equal(rf_write.addr, rf_item.addr, "rf_write addr");
          check_equal(rf_write.data, rf_item.data, "rf_write data");
        end
      end
      if (held_valid) begin
        check_equal(ret_valid, 1'b1, "ret_valid held while stalled");
        check_equal(ret_data === held_data, 1'b1, "ret_data held while stalled");
      end
      if (ret_valid && ret_ready) begin
        if (exp_ret.size() == 0) begin
          abort_run("retirement record with no instruction in flight");
        end else begin
          ret_item = exp_ret.pop_front();
          check_equal(ret_data.instr, ret_item.instr, "record instr");
          check_equal(ret_data.pc, ret_item.pc, "record pc");
          check_equal(ret_data.rd_data, ret_item.rd_data, "record rd_data");
          check_equal({ret_data.rs1_data, ret_data.rs2_data},
                      {ret_item.rs1_data, ret_item.rs2_data}, "record operands");
          check_equal({ret_data.trap, ret_data.trap_code, ret_data.reg_write},
                      {ret_item.trap, ret_item.trap_code, ret_item.reg_write},
                      "record trap and reg_write");
        end
      end
      held_valid = ret_valid && !ret_ready;
      held_data  = ret_data;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run("timeout, the pipeline stopped making progress");
    end
  end

  initial begin
    void'($urandom(32'h429d_4aa4));
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    ret_ready   = 1'b1;
    held_valid  = 1'b0;
    burst_done  = 1'b0;
    cycle_count = 0;
    repeat (3) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;

    test_reset();
    test_result_select();
    test_loads();
    test_mul_div();
    test_backpressure();
    test_latency();
    test_halt();

    if (exp_ret.size() != 0 || exp_rf.size() != 0) begin
      $display("Error: %0d records and %0d register writes never appeared",
               exp_ret.size(), exp_rf.size());
      $display("FAIL: see errors above");
      $fatal(1, "Missing responses");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
+incdir+dv
hdl/rv_wb_pkg.sv
hdl/rv_load_align.sv
hdl/rv_mul_sign_fix.sv
hdl/rv_stage_mem.sv
hdl/rv_stage_wb.sv
hdl/rv_retire_top.sv
dv/rv_retire_tb.sv
